// File: design/sys_info_pkg.sv
// widths, typedefs, bus structs, bus-port states and status address map of the system-info block.
package sys_info_pkg;

    // ======================================================================
    // widths and plain types
    // ======================================================================
    localparam int ADDR_W = 8;                     // status address width.
    localparam int BYTE_W = 8;                     // the viewer reads one byte at a time.
    localparam int BANKS  = 4;                     // SDRAM banks with a ready strobe.

    typedef logic [ADDR_W-1:0] status_addr_t;      // address into the status map.
    typedef logic [BYTE_W-1:0] status_byte_t;      // one byte of status data.
    typedef logic [15:0]       bcd16_t;            // four packed BCD digits.
    typedef logic [BANKS-1:0]  bank_rdy_t;         // one ready pulse per bank.
    typedef logic [1:0]        status_grp_t;       // group field of the address.

    // ======================================================================
    // address map fields
    // ======================================================================
    localparam int GRP_HI         = 7;             // bits 7 and 6 pick the group.
    localparam int GRP_LO         = 6;
    localparam int FRAME_BYTE_BIT = 0;             // set for the high frame-count byte.
    localparam int BANK_HI        = 1;             // bits 1 and 0 pick the SDRAM bank.
    localparam int BANK_LO        = 0;

    localparam status_grp_t GRP_STATS = 2'd0;      // per-bank ready counts.
    localparam status_grp_t GRP_FRAME = 2'd1;      // BCD frame counter.
    localparam status_grp_t GRP_RATE  = 2'd2;      // BCD sample rate.
    localparam status_grp_t GRP_FLIP  = 2'd3;      // screen flip in bit 0.

    // ======================================================================
    // grouped signals
    // ======================================================================
    // live figures sampled from the running core.
    typedef struct packed {
        logic      lvbl;                           // vertical blank, active low.
        logic      sample;                         // audio sample strobe level.
        logic      run;                            // high while the game is not paused.
        logic      flip;                           // screen flip setting.
        bank_rdy_t bank_rdy;                       // SDRAM ready pulses.
    } sys_sense_t;

    // master side of the Wishbone classic port.
    typedef struct packed {
        logic         cyc;
        logic         stb;
        logic         we;
        status_addr_t adr;
        status_byte_t dat_w;
    } wb_req_t;

    // slave side of the Wishbone classic port.
    typedef struct packed {
        logic         ack;
        status_byte_t dat_r;
    } wb_rsp_t;

    typedef enum logic [1:0] {WB_IDLE, WB_LOOKUP, WB_REPLY} wb_state_t;

endpackage

// File: design/bcd_counter.sv
// multi-digit BCD up-counter with synchronous clear and selectable wrap or saturation.
`timescale 1ns/1ps

module bcd_counter #(
    parameter int DIGITS = 4,                      // number of decimal digits.
    parameter bit WRAP   = 1'b1                    // 1 wraps at all nines, 0 holds there.
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                clr,               // synchronous clear, wins over up.
    input  logic                up,                // count one on this clock.
    output logic [DIGITS*4-1:0] cnt
);

    logic [DIGITS*4-1:0] cnt_nxt;                  // value after one more count.
    logic                carry;                    // decimal carry into the next digit.
    logic                all_nines;                // counter is at its top value.

    // ripple the increment through the digits, lowest first.
    always_comb begin
        cnt_nxt   = cnt;
        carry     = 1'b1;                          // the increment enters digit zero.
        all_nines = 1'b1;
        for (int i = 0; i < DIGITS; i++) begin
            if (cnt[i*4 +: 4] != 4'd9) all_nines = 1'b0;
            if (carry) begin
                if (cnt[i*4 +: 4] == 4'd9) begin
                    cnt_nxt[i*4 +: 4] = 4'd0;      // this digit rolls, carry goes on.
                end else begin
                    cnt_nxt[i*4 +: 4] = cnt[i*4 +: 4] + 4'd1;
                    carry             = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (clr) begin
            cnt <= '0;
        end else if (up && (WRAP || !all_nines)) begin
            cnt <= cnt_nxt;                        // at all nines cnt_nxt is already zero.
        end
    end

    // every digit must stay a valid decimal digit.
    for (genvar d = 0; d < DIGITS; d++) begin : g_digit_chk
        a_digit_range: assert property (
            @(posedge clk) disable iff (rst) cnt[d*4 +: 4] <= 4'd9
        );
    end

endmodule

// File: design/bank_stats.sv
// per-bank SDRAM ready counters, latched once per frame at the start of vertical blank.
`timescale 1ns/1ps

module bank_stats
    import sys_info_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         lvbl,                     // vertical blank, active low.
    input  bank_rdy_t    bank_rdy,                 // one ready pulse per bank.
    input  logic [1:0]   bank_sel,                 // bank shown on stat.
    output status_byte_t stat
);

    localparam status_byte_t CNT_MAX = '1;         // counts saturate at 255.

    status_byte_t cnt  [BANKS];                    // running counts for this frame.
    status_byte_t hold [BANKS];                    // counts of the last full frame.
    logic         lvbl_l;                          // lvbl one clock ago.
    logic         blank_start;                     // lvbl has just fallen.

    // a fall of lvbl marks the end of the active frame.
    assign blank_start = lvbl_l & ~lvbl;

    // ======================================================================
    // counting and frame latch
    // ======================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lvbl_l <= 1'b1;                        // idle as active video.
            for (int b = 0; b < BANKS; b++) begin
                cnt[b]  <= '0;
                hold[b] <= '0;
            end
        end else begin
            lvbl_l <= lvbl;
            for (int b = 0; b < BANKS; b++) begin
                if (blank_start) begin
                    hold[b] <= cnt[b];             // publish the finished frame.
                    // a pulse on this very clock belongs to the new frame.
                    cnt[b]  <= status_byte_t'(bank_rdy[b]);
                end else if (bank_rdy[b] && cnt[b] != CNT_MAX) begin
                    cnt[b]  <= cnt[b] + 8'd1;
                end
            end
        end
    end

    // the selected byte goes straight back to the info block.
    assign stat = hold[bank_sel];

    // a full counter has to stay full until the frame latch clears it.
    for (genvar b = 0; b < BANKS; b++) begin : g_sat_chk
        a_no_rollover: assert property (
            @(posedge clk) disable iff (rst)
            (cnt[b] == CNT_MAX && !blank_start) |=> (cnt[b] == CNT_MAX)
        );
    end

endmodule

// File: design/sys_info.sv
// frame counter, windowed sample-rate meter and status byte select.
`timescale 1ns/1ps

module sys_info
    import sys_info_pkg::*;
#(
    parameter int WINDOW_CLKS = 48000              // clocks per sample-rate window.
) (
    input  logic         clk,
    input  logic         rst,
    input  sys_sense_t   sense,                    // live inputs from the core.
    input  status_addr_t st_addr,                  // byte asked for by the bus port.
    output status_byte_t st_dout                   // that byte, one clock later.
);

    localparam int WIN_W = $clog2(WINDOW_CLKS) + 1;

    logic             lvbl_l;                      // lvbl one clock ago.
    logic             sample_l;                    // sample strobe one clock ago.
    logic             frame_up;                    // one pulse per counted frame.
    logic             sample_up;                   // one pulse per sample.
    logic [WIN_W-1:0] win_cnt;                     // position inside the window.
    logic             win_end;                     // last clock of the window.
    bcd16_t           frame_cnt;                   // four BCD digits of frames.
    status_byte_t     scnt;                        // samples so far in this window.
    status_byte_t     srate;                       // samples in the last full window.
    status_byte_t     stats;                       // selected bank count.
    status_grp_t      grp;                         // address group field.

    assign frame_up  = sense.lvbl & ~lvbl_l & sense.run;  // paused frames are not counted.
    assign sample_up = sense.sample & ~sample_l;
    assign win_end   = win_cnt == WIN_W'(WINDOW_CLKS - 1);
    assign grp       = st_addr[GRP_HI:GRP_LO];

    // ======================================================================
    // edge detect and rate window
    // ======================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lvbl_l   <= 1'b1;                      // no false edge if lvbl is high out of reset.
            sample_l <= 1'b1;
            win_cnt  <= '0;
            srate    <= '0;
        end else begin
            lvbl_l   <= sense.lvbl;
            sample_l <= sense.sample;
            if (win_end) begin
                win_cnt <= '0;
                srate   <= scnt;                   // the counter clears on this same clock.
            end else begin
                win_cnt <= win_cnt + 1'b1;
            end
        end
    end

    bcd_counter #(.DIGITS(4), .WRAP(1'b1)) u_frame_cnt (
        .clk (clk),
        .rst (rst),
        .clr (1'b0),
        .up  (frame_up),
        .cnt (frame_cnt)
    );

    // two digits that stop at 99 when the rate overflows the display.
    bcd_counter #(.DIGITS(2), .WRAP(1'b0)) u_sample_cnt (
        .clk (clk),
        .rst (rst),
        .clr (win_end),
        .up  (sample_up),
        .cnt (scnt)
    );

    bank_stats u_bank_stats (
        .clk      (clk),
        .rst      (rst),
        .lvbl     (sense.lvbl),
        .bank_rdy (sense.bank_rdy),
        .bank_sel (st_addr[BANK_HI:BANK_LO]),
        .stat     (stats)
    );

    // ======================================================================
    // status byte select
    // ======================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st_dout <= '0;
        end else begin
            case (grp)
                GRP_STATS: st_dout <= stats;
                GRP_FRAME: st_dout <= st_addr[FRAME_BYTE_BIT] ? frame_cnt[15:8]
                                                              : frame_cnt[7:0];
                GRP_RATE:  st_dout <= srate;
                GRP_FLIP:  st_dout <= {7'd0, sense.flip};
                default:   st_dout <= '0;
            endcase
        end
    end

endmodule

// File: design/status_wb_port.sv
// Wishbone classic slave that turns bus cycles into status lookups with a fixed-latency ack.
`timescale 1ns/1ps

module status_wb_port
    import sys_info_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  wb_req_t      req,                      // master side of the bus.
    input  status_byte_t st_dout,                  // byte returned by the info block.
    output wb_rsp_t      rsp,                      // slave side of the bus.
    output status_addr_t st_addr                   // address handed to the info block.
);

    wb_state_t    state;
    logic         ack_q;                           // single-clock acknowledge.
    status_byte_t dat_r_q;                         // read data held with ack.

    // ======================================================================
    // bus FSM
    // ======================================================================
    // idle captures the address, lookup waits for the registered byte and
    // reply raises ack for one clock before going back to idle.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= WB_IDLE;
            ack_q   <= 1'b0;
            st_addr <= '0;
        end else begin
            case (state)
                WB_IDLE: begin
                    if (req.cyc && req.stb) begin
                        st_addr <= req.adr;        // writes take this path too and change nothing.
                        state   <= WB_LOOKUP;
                    end
                end
                WB_LOOKUP: state <= WB_REPLY;      // info block registers st_dout now.
                WB_REPLY: begin
                    if (ack_q) begin
                        ack_q <= 1'b0;
                        state <= WB_IDLE;
                    end else begin
                        ack_q <= 1'b1;
                    end
                end
                default: state <= WB_IDLE;
            endcase
        end
    end

    // the looked-up byte is captured on the clock that raises ack.
    always_ff @(posedge clk) begin
        if (state == WB_REPLY && !ack_q) dat_r_q <= st_dout;
    end

    assign rsp = '{ack: ack_q, dat_r: dat_r_q};

    a_ack_single: assert property (
        @(posedge clk) disable iff (rst) ack_q |=> !ack_q
    );

    // every ack answers a request seen three edges earlier.
    a_ack_after_req: assert property (
        @(posedge clk) disable iff (rst) $rose(ack_q) |-> $past(req.cyc && req.stb, 3)
    );

endmodule

// File: design/status_top.sv
// top level of the system-info block, joining the Wishbone port and the info block.
`timescale 1ns/1ps

module status_top
    import sys_info_pkg::*;
#(
    parameter int WINDOW_CLKS = 48000              // clocks per sample-rate window.
) (
    input  logic       clk,
    input  logic       rst,                        // asynchronous, active high.
    input  wb_req_t    wb_req,                     // from the debug viewer.
    input  sys_sense_t sense,                      // live figures from the core.
    output wb_rsp_t    wb_rsp                      // back to the debug viewer.
);

    // ======================================================================
    // internal lookup path
    // ======================================================================
    status_addr_t st_addr;                         // address registered by the port.
    status_byte_t st_dout;                         // byte registered by the info block.

    // the bus port owns the handshake and the address register.
    status_wb_port u_wb_port (
        .clk     (clk),
        .rst     (rst),
        .req     (wb_req),
        .st_dout (st_dout),
        .rsp     (wb_rsp),
        .st_addr (st_addr)
    );

    // the info block owns all counters and the byte select.
    sys_info #(
        .WINDOW_CLKS (WINDOW_CLKS)
    ) u_sys_info (
        .clk     (clk),
        .rst     (rst),
        .sense   (sense),
        .st_addr (st_addr),
        .st_dout (st_dout)
    );

endmodule

// File: testbench/tb_status_top.sv
// testbench for status_top with core stimulus and Wishbone reads checked by a reference model.
`timescale 1ns/1ps

module tb_status_top
    import sys_info_pkg::*;
();

    localparam int WINDOW_CLKS    = 200;           // short rate window for simulation.
    localparam int ACTIVE_CLKS    = 40;            // active video clocks per frame.
    localparam int BLANK_CLKS     = 20;
    localparam int ACK_EDGES      = 3;             // fixed read latency of the bus port.
    localparam int TIMEOUT_CYCLES = 20000;         // roughly twice the 9000 stimulus clocks.

    logic         clk = 1'b0;
    logic         rst;
    wb_req_t      wb_req;
    wb_rsp_t      wb_rsp;
    sys_sense_t   sense;

    int           seed;
    int           cycles;                          // clocks since reset, windows align to it.
    int           bus_checks;                      // counted by the bus task.
    int           bus_errors;
    int           cmp_checks;                      // counted by the compare process.
    int           cmp_errors;
    int           frames_run;                      // frames started with run high.
    int           bank_live [4];                   // ready pulses driven in this frame.
    int           bank_hold [4];                   // counts published at the last blank.
    status_byte_t rate_byte;                       // BCD rate of the last full window.
    logic         flip_set;
    logic         busy;                            // a bus cycle is open.
    logic         pend_we;
    status_addr_t pend_addr;

    status_top #(.WINDOW_CLKS(WINDOW_CLKS)) dut (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .sense  (sense),
        .wb_rsp (wb_rsp)
    );

    always #5 clk = ~clk;                          // 10 ns period.

    always @(posedge clk) begin
        if (rst) begin
            cycles <= 0;
        end else if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("checks %0d, errors %0d", bus_checks + cmp_checks, bus_errors + cmp_errors);
            $display("TEST FAILED");
            $finish;
        end else begin
            cycles <= cycles + 1;
        end
    end

    // ======================================================================
    // reference model
    // ======================================================================
    function automatic bcd16_t to_bcd(input int value);
        bcd16_t bcd;
        int     v;
        v = value;
        for (int d = 0; d < 4; d++) begin
            bcd[d*4 +: 4] = 4'(v % 10);            // digits above the fourth fall away.
            v = v / 10;
        end
        return bcd;
    endfunction

    // expected byte for an address from the shadow counts.
    function automatic status_byte_t ref_byte(input status_addr_t adr);
        bcd16_t frames;
        frames = to_bcd(frames_run);
        case (adr[7:6])
            GRP_STATS: return status_byte_t'(bank_hold[adr[1:0]]);
            GRP_FRAME: return adr[0] ? frames[15:8] : frames[7:0];
            GRP_RATE:  return rate_byte;
            default:   return {7'd0, flip_set};
        endcase
    endfunction

    // every ack is looked at in the middle of its clock.
    always @(negedge clk) begin : compare
        status_byte_t expected;
        if (!rst && wb_rsp.ack) begin
            cmp_checks++;
            assert (busy) else begin
                cmp_errors++;
                $display("ack was raised while no bus cycle was open");
            end
            if (!pend_we) begin
                expected = ref_byte(pend_addr);
                cmp_checks++;
                assert (wb_rsp.dat_r == expected) else begin
                    cmp_errors++;
                    $display("[ERROR] wb_rsp.dat_r at adr 0x%h: got 0x%h, expected 0x%h",
                             pend_addr, wb_rsp.dat_r, expected);
                end
            end
        end
    end

    // ======================================================================
    // stimulus tasks
    // ======================================================================
    // one Wishbone classic cycle; the request edge is the first edge after the drive.
    task automatic bus_cycle(input logic we, input status_addr_t adr, input status_byte_t dat);
        int edges;
        @(posedge clk);
        busy      = 1'b1;
        pend_we   = we;
        pend_addr = adr;
        wb_req   <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: dat};
        edges     = 0;
        do begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end while (!wb_rsp.ack && edges < 2 * ACK_EDGES);
        bus_checks += 2;
        assert (wb_rsp.ack) else begin
            bus_errors++;
            $display("no ack came for the cycle at adr 0x%h", adr);
        end
        assert (edges == ACK_EDGES) else begin
            bus_errors++;
            $display("[ERROR] wb_rsp.ack edges at adr 0x%h: got 0x%h, expected 0x%h",
                     adr, edges, ACK_EDGES);
        end
        @(posedge clk);
        wb_req <= '0;                              // the master closes the cycle after ack.
        @(negedge clk);
        bus_checks++;
        assert (!wb_rsp.ack) else begin
            bus_errors++;
            $display("[ERROR] wb_rsp.ack one clock later: got 0x1, expected 0x0");
        end
        busy = 1'b0;
    endtask

    task automatic check_map();
        for (int b = 0; b < 4; b++) begin
            bus_cycle(1'b0, status_addr_t'(b), '0);
        end
        bus_cycle(1'b0, 8'h40, '0);
        bus_cycle(1'b0, 8'h41, '0);
        bus_cycle(1'b0, 8'hC0, '0);
    endtask

    // active video with random ready pulses, then blanking.
    task automatic run_frame(input logic run_v, input int active_clks, input logic hog_bank2);
        bank_rdy_t rdy;
        @(posedge clk);
        sense.run  <= run_v;
        sense.lvbl <= 1'b1;                        // the rising edge counts the frame.
        if (run_v) frames_run++;
        repeat (active_clks) begin
            @(posedge clk);
            rdy = bank_rdy_t'($random(seed));
            if (hog_bank2) rdy[2] = 1'b1;          // bank 2 busy every clock.
            sense.bank_rdy <= rdy;
            for (int b = 0; b < 4; b++) begin
                if (rdy[b]) bank_live[b]++;
            end
        end
        @(posedge clk);
        sense.bank_rdy <= '0;
        sense.lvbl     <= 1'b0;                    // start of blanking publishes the counts.
        for (int b = 0; b < 4; b++) begin
            bank_hold[b] = (bank_live[b] > 255) ? 255 : bank_live[b];
            bank_live[b] = 0;
        end
        repeat (BLANK_CLKS) @(posedge clk);
    endtask

    task automatic wait_window_end();
        do @(negedge clk); while (cycles % WINDOW_CLKS != 0);
    endtask

    // sample pulses in one window. A flood toggles the strobe every clock through
    // the rest of this window and the whole next one, which then holds 100 rises.
    task automatic sample_window(input int pulses, input logic flood);
        int     gap;
        int     rises;
        bcd16_t bcd;
        wait_window_end();
        rises = 0;
        if (flood) begin
            for (int i = 1; i < 2 * WINDOW_CLKS; i++) begin
                @(posedge clk);
                sense.sample <= !i[0];
                if (i >= WINDOW_CLKS && !i[0]) rises++;  // rises seen inside the full window.
            end
        end else begin
            for (int i = 0; i < pulses; i++) begin
                gap = 1 + ($random(seed) & 3);
                repeat (gap) begin
                    @(posedge clk);
                    sense.sample <= 1'b0;
                end
                @(posedge clk);
                sense.sample <= 1'b1;
                rises++;
            end
        end
        @(posedge clk);
        sense.sample <= 1'b0;
        wait_window_end();
        bcd       = to_bcd((rises > 99) ? 99 : rises);
        rate_byte = bcd[7:0];
    endtask

    // ======================================================================
    // test sequence
    // ======================================================================
    initial begin
        seed = 7221;
        rst    <= 1'b1;
        wb_req <= '0;
        sense  <= '0;                              // blanking, paused, no samples.
        {bus_checks, bus_errors, cmp_checks, cmp_errors, frames_run} = '0;
        rate_byte = '0;
        {flip_set, busy, pend_we} = '0;
        pend_addr = '0;
        for (int b = 0; b < 4; b++) begin
            bank_live[b] = 0;
            bank_hold[b] = 0;
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        check_map();                               // all zero out of reset.
        bus_cycle(1'b0, 8'h80, '0);
        for (int f = 1; f >= 0; f--) begin
            @(posedge clk);
            sense.flip <= f[0];
            flip_set    = f[0];
            bus_cycle(1'b0, 8'hC0, '0);
        end

        repeat (12) run_frame(1'b1, ACTIVE_CLKS, 1'b0);
        repeat (5) run_frame(1'b0, ACTIVE_CLKS, 1'b0);   // paused frames do not count.
        check_map();
        repeat (87) run_frame(1'b1, ACTIVE_CLKS, 1'b0);
        check_map();
        repeat (6) run_frame(1'b1, ACTIVE_CLKS, 1'b0);   // decimal carry into the hundreds.
        check_map();
        run_frame(1'b1, 300, 1'b1);
        check_map();

        // writes land nowhere so the map reads the same afterwards.
        repeat (6) bus_cycle(1'b1, status_addr_t'($random(seed)), status_byte_t'($random(seed)));
        check_map();
        repeat (12) bus_cycle(1'b0, status_addr_t'($random(seed)), '0);

        sample_window(37, 1'b0);
        bus_cycle(1'b0, 8'h80, '0);
        sample_window(10 + ($random(seed) & 15), 1'b0);
        bus_cycle(1'b0, 8'h80, '0);
        sample_window(0, 1'b1);
        bus_cycle(1'b0, 8'h80, '0);

        $display("checks %0d, errors %0d", bus_checks + cmp_checks, bus_errors + cmp_errors);
        if (bus_errors + cmp_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
design/sys_info_pkg.sv
design/bcd_counter.sv
design/bank_stats.sv
design/sys_info.sv
design/status_wb_port.sv
design/status_top.sv
testbench/tb_status_top.sv

// File: run_sim.sh
#!/bin/sh
# compiles and runs the status_top testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --top-module tb_status_top -Mdir "$OBJ" -f build.f
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

"./$OBJ/Vtb_status_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST OK$" "$LOG"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see $LOG"
exit 1
